/* hdl/mem_test_pkg.sv */
/*
  shared definitions for the DDR2 local-port traffic generator
  - local port and address field widths
  - burst shape and address range limits
  - per-lane LFSR seeds
  - test_status bit positions
  - data word with flat and byte-lane views
*/
package mem_test_pkg;

  // ------------------------------
  // local port widths
  // ------------------------------
  localparam int data_w = 16;
  localparam int lane_n = 2;
  localparam int bank_w = 2;
  localparam int row_w  = 13;
  localparam int col_w  = 10;
  localparam int size_w = 3;

  // ------------------------------
  // burst shape and address range
  // ------------------------------
  localparam int burst_len = 2;
  // two beats of a 16-bit half-rate word cover four columns
  localparam int col_step  = 4;
  localparam int max_col   = 16;
  localparam int max_row   = 3;
  localparam int max_bank  = 3;

  // lane 0 seeded with 1, lane 1 with 11
  localparam logic [lane_n-1:0][7:0] lane_seed = {8'd11, 8'd1};

  // test_status bits
  localparam int stat_seq_bit  = 0;
  localparam int stat_dm_bit   = 2;
  localparam int stat_done_bit = 7;

  // one local data word, seen whole or per byte lane
  typedef union packed {
    logic [data_w-1:0]      flat;
    logic [lane_n-1:0][7:0] lane;
  } mem_word_t;

endpackage

/* hdl/pattern_gen.sv */
/*
  data and byte-enable generator
  - one 8-bit Fibonacci LFSR per byte lane
  - reload store for the first word of a write pass
  - one-hot rotating byte enable for the data-mask test
*/
`timescale 1ns/1ps

module pattern_gen (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            local_ready,
  input  logic                            local_write_req,
  input  logic                            local_rdata_valid,
  input  logic                            gen_load,
  input  logic                            fill_zero,
  input  logic                            mask_mode,
  input  logic                            wait_first,
  output mem_test_pkg::mem_word_t         wdata,
  output mem_test_pkg::mem_word_t         expect_word,
  output logic [mem_test_pkg::lane_n-1:0] local_be
);
  import mem_test_pkg::*;

  mem_word_t         lfsr;
  mem_word_t         reload_word;
  logic              advance;
  logic              mask_active;
  logic [lane_n-1:0] be_start;

  // taps 8, 6, 5, 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] d);
    return {d[6:0], d[7] ^ d[5] ^ d[4] ^ d[3]};
  endfunction

  // zero-fill beats leave the sequence where it is
  assign advance     = (local_write_req & local_ready & ~fill_zero) | local_rdata_valid;
  assign mask_active = mask_mode & ~fill_zero;
  assign be_start    = mask_active ? lane_n'(1) : '1;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lfsr.lane <= lane_seed;
    end
    else if (gen_load)
    begin
      lfsr <= reload_word;
    end
    else if (advance)
    begin
      for (int i = 0; i < lane_n; i++)
      begin
        lfsr.lane[i] <= lfsr_next(lfsr.lane[i]);
      end
    end
  end

  // replay point for the read pass
  always_ff @(posedge clk)
  begin
    if (wait_first)
    begin
      reload_word <= lfsr;
    end
  end

  // ------------------------------
  // byte enable
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      local_be <= '1;
    end
    else if (gen_load)
    begin
      local_be <= be_start;
    end
    else if (advance & mask_active)
    begin
      local_be <= {local_be[lane_n-2:0], local_be[lane_n-1]};
    end
    else if (!mask_active)
    begin
      local_be <= '1;
    end
  end

  assign wdata       = fill_zero ? '0 : lfsr;
  assign expect_word = lfsr;

endmodule

/* hdl/addr_sequencer.sv */
/*
  burst address counter
  - column steps by one burst, then carries into row and bank
  - at_last flags the final burst of the range
*/
`timescale 1ns/1ps

module addr_sequencer (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            addr_clear,
  input  logic                            addr_step,
  output logic [mem_test_pkg::bank_w-1:0] local_bank_addr,
  output logic [mem_test_pkg::row_w-1:0]  local_row_addr,
  output logic [mem_test_pkg::col_w-1:0]  local_col_addr,
  output logic                            at_last
);
  import mem_test_pkg::*;

  logic col_end;
  logic row_end;
  logic bank_end;

  assign col_end  = local_col_addr == col_w'(max_col);
  assign row_end  = local_row_addr == row_w'(max_row);
  assign bank_end = local_bank_addr == bank_w'(max_bank);
  assign at_last  = col_end & row_end & bank_end;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      local_bank_addr <= '0;
      local_row_addr  <= '0;
      local_col_addr  <= '0;
    end
    else if (addr_clear)
    begin
      local_bank_addr <= '0;
      local_row_addr  <= '0;
      local_col_addr  <= '0;
    end
    else if (addr_step)
    begin
      if (col_end)
      begin
        local_col_addr <= '0;
        if (row_end)
        begin
          local_row_addr <= '0;
          // full carry wraps back to bank 0
          local_bank_addr <= bank_end ? '0 : local_bank_addr + 1'b1;
        end
        else
        begin
          local_row_addr <= local_row_addr + 1'b1;
        end
      end
      else
      begin
        local_col_addr <= local_col_addr + col_w'(col_step);
      end
    end
  end

endmodule

/* hdl/read_checker.sv */
/*
  read data checker
  - per-lane masked compare, three register stages to pnf_per_byte
  - sticky overall pass flag
  - status word from mode and completion bits
*/
`timescale 1ns/1ps

module read_checker (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic [mem_test_pkg::data_w-1:0] local_rdata,
  input  logic                            local_rdata_valid,
  input  mem_test_pkg::mem_word_t         expect_word,
  input  logic [mem_test_pkg::lane_n-1:0] local_be,
  input  logic                            seq_mode,
  input  logic                            mask_mode,
  input  logic                            test_complete,
  output logic [mem_test_pkg::lane_n-1:0] pnf_per_byte,
  output logic                            pnf_persist,
  output logic [7:0]                      test_status
);
  import mem_test_pkg::*;

  mem_word_t         rdata_word;
  logic [lane_n-1:0] compare;
  logic [lane_n-1:0] compare_reg;
  logic [lane_n-1:0] compare_valid;
  logic              valid_d1;
  logic              rd_seen;
  logic              rd_seen_d1;
  logic              pnf_fail;

  assign rdata_word.flat = local_rdata;

  // disabled lanes expect zero
  always_comb
  begin
    for (int i = 0; i < lane_n; i++)
    begin
      compare[i] = (expect_word.lane[i] & {8{local_be[i]}}) == rdata_word.lane[i];
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg   <= '1;
      compare_valid <= '1;
      pnf_per_byte  <= '1;
      valid_d1      <= 1'b0;
      rd_seen       <= 1'b0;
      rd_seen_d1    <= 1'b0;
      pnf_fail      <= 1'b0;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      compare_reg <= compare;
      valid_d1    <= local_rdata_valid;
      // only a real read beat updates the lane result
      if (valid_d1)
      begin
        compare_valid <= compare_reg;
      end
      pnf_per_byte <= compare_valid;
      rd_seen      <= rd_seen | local_rdata_valid;
      rd_seen_d1   <= rd_seen;
      pnf_fail     <= pnf_fail | ~&pnf_per_byte;
      pnf_persist  <= rd_seen_d1 & (&pnf_per_byte) & ~pnf_fail;
    end
  end

  always_comb
  begin
    test_status                = '0;
    test_status[stat_seq_bit]  = seq_mode;
    test_status[stat_dm_bit]   = mask_mode;
    test_status[stat_done_bit] = test_complete;
  end

endmodule

/* hdl/test_sequencer.sv */
/*
  test control FSM
  - sequential test: write pass, read pass
  - data-mask test: zero-fill pass, masked write pass, read pass
  - beat count within a write burst, outstanding read beats
*/
`timescale 1ns/1ps

module test_sequencer (
  input  logic clk,
  input  logic reset_n,
  input  logic local_ready,
  input  logic local_rdata_valid,
  input  logic at_last,
  output logic local_write_req,
  output logic local_read_req,
  output logic local_burstbegin,
  output logic addr_clear,
  output logic addr_step,
  output logic gen_load,
  output logic fill_zero,
  output logic mask_mode,
  output logic wait_first,
  output logic seq_mode,
  output logic test_complete
);
  import mem_test_pkg::*;

  logic [2:0]        state;
  logic [size_w-1:0] beat_cnt;
  logic [7:0]        rd_pending;
  logic              wr_accept;
  logic              rd_accept;
  logic              last_beat;
  logic              wr_setup;

  assign wr_accept = local_write_req & local_ready;
  assign rd_accept = local_read_req & local_ready;
  assign last_beat = beat_cnt == size_w'(burst_len - 1);
  assign wr_setup  = state == 3'd1;

  // one read request stands for a whole burst
  assign addr_step  = (wr_accept & last_beat) | rd_accept;
  assign addr_clear = wr_setup | (state == 3'd3);
  // masked pass keeps the seed stored by the zero-fill pass
  assign wait_first = wr_setup & ~(mask_mode & ~fill_zero);
  assign gen_load   = (state == 3'd3) | (wr_setup & mask_mode & ~fill_zero);

  // outstanding read beats
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pending <= '0;
    end
    else
    begin
      rd_pending <= rd_pending + (rd_accept ? 8'(burst_len) : 8'd0)
                    - {7'd0, local_rdata_valid};
    end
  end

  // ------------------------------
  // main FSM
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state            <= 3'd0;
      beat_cnt         <= '0;
      local_write_req  <= 1'b0;
      local_read_req   <= 1'b0;
      local_burstbegin <= 1'b0;
      fill_zero        <= 1'b0;
      mask_mode        <= 1'b0;
      seq_mode         <= 1'b0;
      test_complete    <= 1'b0;
    end
    else
    begin
      case (state)
        // start, sequential test first
        3'd0:
        begin
          seq_mode <= 1'b1;
          state    <= 3'd1;
        end
        // write pass setup
        3'd1:
        begin
          local_write_req  <= 1'b1;
          local_burstbegin <= 1'b1;
          beat_cnt         <= '0;
          state            <= 3'd2;
        end
        // write beats, frozen until accepted
        3'd2:
        begin
          if (wr_accept)
          begin
            if (last_beat)
            begin
              beat_cnt <= '0;
              if (at_last)
              begin
                local_write_req  <= 1'b0;
                local_burstbegin <= 1'b0;
                fill_zero        <= 1'b0;
                // zero fill is followed by the masked write pass
                state            <= fill_zero ? 3'd1 : 3'd3;
              end
              else
              begin
                local_burstbegin <= 1'b1;
              end
            end
            else
            begin
              beat_cnt         <= beat_cnt + 1'b1;
              local_burstbegin <= 1'b0;
            end
          end
        end
        // read pass setup
        3'd3:
        begin
          local_read_req   <= 1'b1;
          local_burstbegin <= 1'b1;
          state            <= 3'd4;
        end
        // one read request per burst
        3'd4:
        begin
          if (rd_accept & at_last)
          begin
            local_read_req   <= 1'b0;
            local_burstbegin <= 1'b0;
            state            <= 3'd5;
          end
        end
        // wait for every read beat before changing test
        3'd5:
        begin
          if (rd_pending == 8'd0)
          begin
            if (seq_mode)
            begin
              seq_mode  <= 1'b0;
              mask_mode <= 1'b1;
              fill_zero <= 1'b1;
              state     <= 3'd1;
            end
            else
            begin
              mask_mode     <= 1'b0;
              test_complete <= 1'b1;
              state         <= 3'd6;
            end
          end
        end
        // done, idle until reset
        3'd6:
        begin
          state <= 3'd6;
        end
        default:
        begin
          state <= 3'd0;
        end
      endcase
    end
  end

endmodule

/* hdl/mem_test_driver.sv */
/*
  DDR2 local-port traffic generator, top level
  - FSM, address counter, data generator, read checker
*/
`timescale 1ns/1ps

module mem_test_driver (
  input  logic                            clk,
  input  logic                            reset_n,
  output logic                            local_write_req,
  output logic                            local_read_req,
  output logic                            local_burstbegin,
  output logic [mem_test_pkg::bank_w-1:0] local_bank_addr,
  output logic [mem_test_pkg::row_w-1:0]  local_row_addr,
  output logic [mem_test_pkg::col_w-1:0]  local_col_addr,
  output logic [mem_test_pkg::size_w-1:0] local_size,
  output logic [mem_test_pkg::lane_n-1:0] local_be,
  output logic [mem_test_pkg::data_w-1:0] local_wdata,
  input  logic                            local_ready,
  input  logic [mem_test_pkg::data_w-1:0] local_rdata,
  input  logic                            local_rdata_valid,
  output logic [mem_test_pkg::lane_n-1:0] pnf_per_byte,
  output logic                            pnf_persist,
  output logic                            test_complete,
  output logic [7:0]                      test_status
);
  import mem_test_pkg::*;

  logic      addr_clear;
  logic      addr_step;
  logic      at_last;
  logic      gen_load;
  logic      fill_zero;
  logic      mask_mode;
  logic      wait_first;
  logic      seq_mode;
  mem_word_t wdata_word;
  mem_word_t expect_word;

  assign local_wdata = wdata_word.flat;
  assign local_size  = size_w'(burst_len);

  test_sequencer u_test_sequencer (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .at_last           (at_last),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .addr_clear        (addr_clear),
    .addr_step         (addr_step),
    .gen_load          (gen_load),
    .fill_zero         (fill_zero),
    .mask_mode         (mask_mode),
    .wait_first        (wait_first),
    .seq_mode          (seq_mode),
    .test_complete     (test_complete)
  );

  addr_sequencer u_addr_sequencer (
    .clk             (clk),
    .reset_n         (reset_n),
    .addr_clear      (addr_clear),
    .addr_step       (addr_step),
    .local_bank_addr (local_bank_addr),
    .local_row_addr  (local_row_addr),
    .local_col_addr  (local_col_addr),
    .at_last         (at_last)
  );

  pattern_gen u_pattern_gen (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_write_req   (local_write_req),
    .local_rdata_valid (local_rdata_valid),
    .gen_load          (gen_load),
    .fill_zero         (fill_zero),
    .mask_mode         (mask_mode),
    .wait_first        (wait_first),
    .wdata             (wdata_word),
    .expect_word       (expect_word),
    .local_be          (local_be)
  );

  read_checker u_read_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .expect_word       (expect_word),
    .local_be          (local_be),
    .seq_mode          (seq_mode),
    .mask_mode         (mask_mode),
    .test_complete     (test_complete),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_status       (test_status)
  );

endmodule

/* verification/mem_test_props.sv */
/*
  local-port protocol assertions, bound to mem_test_driver
  - request, address, be and wdata hold during a stall
  - one request kind at a time, burstbegin only with a request
*/
`timescale 1ns/1ps

module mem_test_props (
  input logic                            clk,
  input logic                            reset_n,
  input logic                            local_write_req,
  input logic                            local_read_req,
  input logic                            local_burstbegin,
  input logic [mem_test_pkg::bank_w-1:0] local_bank_addr,
  input logic [mem_test_pkg::row_w-1:0]  local_row_addr,
  input logic [mem_test_pkg::col_w-1:0]  local_col_addr,
  input logic [mem_test_pkg::lane_n-1:0] local_be,
  input logic [mem_test_pkg::data_w-1:0] local_wdata,
  input logic                            local_ready
);

  int fail_count = 0;

  // stalled write beat keeps everything
  wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (local_write_req && !local_ready) |=> $stable({local_write_req, local_burstbegin,
      local_bank_addr, local_row_addr, local_col_addr, local_be, local_wdata}))
    else
    begin
      fail_count++;
      $error("write beat changed while local_ready was low");
    end

  rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (local_read_req && !local_ready) |=> $stable({local_read_req, local_burstbegin,
      local_bank_addr, local_row_addr, local_col_addr}))
    else
    begin
      fail_count++;
      $error("read request changed while local_ready was low");
    end

  one_req: assert property (@(posedge clk) disable iff (!reset_n)
    !(local_write_req && local_read_req))
    else
    begin
      fail_count++;
      $error("write and read requested together");
    end

  bb_req: assert property (@(posedge clk) disable iff (!reset_n)
    local_burstbegin |-> (local_write_req || local_read_req))
    else
    begin
      fail_count++;
      $error("burstbegin without a request");
    end

endmodule

bind mem_test_driver mem_test_props u_mem_test_props (.*);

/* verification/mem_test_checker.sv */
/*
  testbench checker
  - LFSR and address model of each pass
  - write beat, read request and status checks
  - pnf_per_byte and pnf_persist model with the 3-cycle delay
*/
`timescale 1ns/1ps

module mem_test_checker (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            fault_run,
  input  logic                            local_write_req,
  input  logic                            local_read_req,
  input  logic                            local_burstbegin,
  input  logic [mem_test_pkg::bank_w-1:0] local_bank_addr,
  input  logic [mem_test_pkg::row_w-1:0]  local_row_addr,
  input  logic [mem_test_pkg::col_w-1:0]  local_col_addr,
  input  logic [mem_test_pkg::size_w-1:0] local_size,
  input  logic [mem_test_pkg::lane_n-1:0] local_be,
  input  logic [mem_test_pkg::data_w-1:0] local_wdata,
  input  logic                            local_ready,
  input  logic [mem_test_pkg::data_w-1:0] local_rdata,
  input  logic                            local_rdata_valid,
  input  logic [mem_test_pkg::lane_n-1:0] pnf_per_byte,
  input  logic                            pnf_persist,
  input  logic                            test_complete,
  input  logic [7:0]                      test_status,
  output int                              value_errors,
  output int                              other_errors
);
  import mem_test_pkg::*;

  localparam int n_col    = max_col / col_step + 1;
  localparam int n_burst  = n_col * (max_row + 1) * (max_bank + 1);
  localparam int pass_len = n_burst * burst_len;

  logic [7:0]        pat [lane_n][2*pass_len];
  logic [lane_n-1:0] exp_pnf;
  logic [lane_n-1:0] res_q [$];
  int                due_q [$];
  int                cyc;
  int                wr_beats;
  int                rd_reqs;
  int                rd_beats;
  int                first_valid;
  int                fail_beats;
  bit                fail_seen;
  bit                done_seen;

  // taps 8, 6, 5, 4 as a bit mask
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], ^(s & 8'hb8)};
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    value_errors++;
    $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
  endtask

  task automatic report_issue(input string msg);
    other_errors++;
    $display("checker: %s at %0t", msg, $time);
  endtask

  // burst b in bank, row, column carry order
  task automatic check_addr(input int b, input string kind);
    logic [31:0] exp;
    logic [31:0] got;
    exp = {8'(b / (n_col * (max_row + 1))), 8'((b / n_col) % (max_row + 1)),
           16'((b % n_col) * col_step)};
    got = {8'(local_bank_addr), 8'(local_row_addr), 16'(local_col_addr)};
    if (got !== exp)
      report_value({kind, " address"}, exp, got);
    if (local_size !== size_w'(burst_len))
      report_value("local_size", burst_len, local_size);
  endtask

  initial
  begin
    value_errors = 0;
    other_errors = 0;
    for (int l = 0; l < lane_n; l++)
    begin
      pat[l][0] = lane_seed[l];
      for (int i = 1; i < 2 * pass_len; i++)
        pat[l][i] = lfsr_step(pat[l][i-1]);
    end
  end

  always @(posedge clk)
  begin : model
    int                k;
    int                p;
    bit                exp_persist;
    logic [lane_n-1:0] exp_be;
    logic [lane_n-1:0] res;
    logic [7:0]        exp_byte;
    if (!reset_n)
    begin
      cyc = 0;
      wr_beats = 0;
      rd_reqs = 0;
      rd_beats = 0;
      first_valid = -1;
      fail_beats = 0;
      fail_seen = 0;
      done_seen = 0;
      exp_pnf = '1;
      res_q.delete();
      due_q.delete();
    end
    else
    begin
      cyc++;
      // ------------------------------
      // pass flags
      // ------------------------------
      exp_persist = first_valid >= 0 && cyc >= first_valid + 3 && !fail_seen;
      if (due_q.size() > 0 && due_q[0] == cyc)
      begin
        exp_pnf = res_q.pop_front();
        void'(due_q.pop_front());
      end
      if (pnf_per_byte !== exp_pnf)
        report_value("pnf_per_byte", exp_pnf, pnf_per_byte);
      if (pnf_persist !== exp_persist)
        report_value("pnf_persist", exp_persist, pnf_persist);
      fail_seen = fail_seen | ~&exp_pnf;

      // ------------------------------
      // write beats
      // ------------------------------
      if (local_write_req && local_ready)
      begin
        k = wr_beats % pass_len;
        p = wr_beats / pass_len;
        check_addr(k / burst_len, "write");
        if (local_burstbegin !== (k % burst_len == 0))
          report_value("local_burstbegin", k % burst_len == 0, local_burstbegin);
        if (test_status !== (p == 0 ? 8'h01 : 8'h04))
          report_value("test_status", p == 0 ? 8'h01 : 8'h04, test_status);
        exp_be = (p == 2) ? lane_n'(1) << (k % lane_n) : '1;
        if (local_be !== exp_be)
          report_value("local_be", exp_be, local_be);
        for (int l = 0; l < lane_n; l++)
        begin
          exp_byte = (p == 0) ? pat[l][k] : (p == 1) ? 8'h00 : pat[l][pass_len + k];
          if (exp_be[l] && local_wdata[8*l +: 8] !== exp_byte)
            report_value($sformatf("local_wdata lane %0d", l), exp_byte, local_wdata[8*l +: 8]);
        end
        wr_beats++;
      end

      if (local_read_req && local_ready)
      begin
        check_addr(rd_reqs % n_burst, "read");
        if (local_burstbegin !== 1'b1)
          report_value("local_burstbegin", 1, local_burstbegin);
        if (test_status !== (rd_reqs < n_burst ? 8'h01 : 8'h04))
          report_value("test_status", rd_reqs < n_burst ? 8'h01 : 8'h04, test_status);
        rd_reqs++;
      end

      // read beats replay the write data of the pass
      if (local_rdata_valid)
      begin
        k = rd_beats % pass_len;
        p = rd_beats / pass_len;
        if (first_valid < 0)
          first_valid = cyc;
        exp_be = (p == 1) ? lane_n'(1) << (k % lane_n) : '1;
        for (int l = 0; l < lane_n; l++)
        begin
          exp_byte = (p == 0 ? pat[l][k] : pat[l][pass_len + k]) & {8{exp_be[l]}};
          res[l] = local_rdata[8*l +: 8] == exp_byte;
        end
        if (res != '1)
          fail_beats++;
        res_q.push_back(res);
        due_q.push_back(cyc + 3);
        rd_beats++;
      end

      if (test_complete && !done_seen)
      begin
        done_seen = 1;
        if (test_status !== 8'h80)
          report_value("test_status", 8'h80, test_status);
        if (wr_beats != 3 * pass_len || rd_reqs != 2 * n_burst || rd_beats != 2 * pass_len)
          report_issue($sformatf("run ended after %0d write beats, %0d reads, %0d read beats",
                                 wr_beats, rd_reqs, rd_beats));
        if (fail_beats != (fault_run ? 1 : 0))
          report_issue($sformatf("%0d failing read beats seen in this run", fail_beats));
      end
    end
  end

endmodule

/* verification/tb_mem_test_driver.sv */
/*
  testbench top for mem_test_driver
  - clock, reset, memory responder with random stalls and latency
  - one clean run, then one run with a flipped read lane
  - watchdog and closing report
*/
`timescale 1ns/1ps

module tb_mem_test_driver;
  import mem_test_pkg::*;

  localparam int  pass_cycles = 2000;
  localparam int  fault_beat  = 57;
  localparam int  fault_lane  = 1;
  localparam time watchdog_ns = 2 * 5 * pass_cycles * 10;

  logic                clk;
  logic                reset_n;
  logic                fault_run;
  logic                local_write_req;
  logic                local_read_req;
  logic                local_burstbegin;
  logic [bank_w-1:0]   local_bank_addr;
  logic [row_w-1:0]    local_row_addr;
  logic [col_w-1:0]    local_col_addr;
  logic [size_w-1:0]   local_size;
  logic [lane_n-1:0]   local_be;
  logic [data_w-1:0]   local_wdata;
  logic                local_ready;
  logic [data_w-1:0]   local_rdata;
  logic                local_rdata_valid;
  logic [lane_n-1:0]   pnf_per_byte;
  logic                pnf_persist;
  logic                test_complete;
  logic [7:0]          test_status;
  int                  value_errors;
  int                  other_errors;
  int                  assert_errors;
  logic [31:0]         rng_state;
  logic [data_w-1:0]   mem [int];
  int                  due_q [$];
  int                  idx_q [$];
  int                  cyc;
  int                  last_due;
  int                  wr_beat;
  int                  rd_beat;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  mem_test_driver u_mem_test_driver (.*);

  mem_test_checker u_mem_test_checker (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // memory responder
  // ------------------------------
  always @(posedge clk)
  begin : responder
    int          idx;
    int          due;
    logic [15:0] word;
    if (!reset_n)
    begin
      due_q.delete();
      idx_q.delete();
      cyc = 0;
      last_due = 0;
      wr_beat = 0;
      rd_beat = 0;
      #1;
      local_ready = 1'b1;
      local_rdata_valid = 1'b0;
    end
    else
    begin
      cyc++;
      idx = {local_bank_addr, local_row_addr, local_col_addr};
      if (local_write_req && local_ready)
      begin
        wr_beat = local_burstbegin ? 0 : wr_beat + 1;
        word = mem.exists(idx + wr_beat) ? mem[idx + wr_beat] : '0;
        for (int l = 0; l < lane_n; l++)
          if (local_be[l])
            word[8*l +: 8] = local_wdata[8*l +: 8];
        mem[idx + wr_beat] = word;
      end
      // bursts come back in order, 2 to 8 cycles late
      if (local_read_req && local_ready)
      begin
        due = cyc + 2 + int'(xorshift() % 7);
        if (due <= last_due)
          due = last_due + 1;
        for (int b = 0; b < burst_len; b++)
        begin
          due_q.push_back(due + b);
          idx_q.push_back(idx + b);
        end
        last_due = due + burst_len - 1;
      end
      #1;
      local_rdata_valid = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc)
      begin
        void'(due_q.pop_front());
        idx = idx_q.pop_front();
        local_rdata = mem.exists(idx) ? mem[idx] : '0;
        if (fault_run && rd_beat == fault_beat)
          local_rdata[8*fault_lane +: 8] = local_rdata[8*fault_lane +: 8] ^ 8'h5a;
        local_rdata_valid = 1'b1;
        rd_beat++;
      end
      local_ready = (xorshift() & 32'h3) != 0;
    end
  end

  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 reset_n = 1'b1;
  endtask

  initial
  begin
    rng_state = 32'hcaeb0efa;
    reset_n = 1'b0;
    fault_run = 1'b0;
    local_ready = 1'b1;
    local_rdata = '0;
    local_rdata_valid = 1'b0;
    for (int run = 0; run < 2; run++)
    begin
      fault_run = run == 1;
      apply_reset();
      wait (test_complete === 1'b1);
      repeat (5) @(posedge clk);
      #1 reset_n = 1'b0;
    end
    assert_errors = u_mem_test_driver.u_mem_test_props.fail_count;
    $display("value errors %0d, other errors %0d, assertion errors %0d",
             value_errors, other_errors, assert_errors);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(watchdog_ns);
    $display("timeout: test_complete did not rise in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* mem_test_driver.f */
hdl/mem_test_pkg.sv
hdl/pattern_gen.sv
hdl/addr_sequencer.sv
hdl/read_checker.sv
hdl/test_sequencer.sv
hdl/mem_test_driver.sv
verification/mem_test_props.sv
verification/mem_test_checker.sv
verification/tb_mem_test_driver.sv

/* Bender.yml */
package:
  name: mem_test_driver

sources:
  - files:
      - hdl/mem_test_pkg.sv
      - hdl/pattern_gen.sv
      - hdl/addr_sequencer.sv
      - hdl/read_checker.sv
      - hdl/test_sequencer.sv
      - hdl/mem_test_driver.sv
  - target: test
    files:
      - verification/mem_test_props.sv
      - verification/mem_test_checker.sv
      - verification/tb_mem_test_driver.sv
